/* rtl/adc_pkg.sv */
package adc_pkg;

    // Lane layout of the TDM sample port
    localparam int lane_count = 8;

    // Raw sample bits per lane in one frame
    localparam int packet_bits = 24;

    // All lanes packed side by side
    localparam int frame_bits = lane_count * packet_bits;

    // One lane's packet as shifted in, first bit on top
    typedef logic [packet_bits-1:0] adc_packet_t;

    // Ascending range keeps lane 0 in the most significant bits
    typedef adc_packet_t [0:lane_count-1] adc_frame_t;

    // One bit per data lane pin
    typedef logic [lane_count-1:0] lane_bus_t;

endpackage

/* rtl/stream_pkg.sv */
package stream_pkg;

    // One ADC frame fills one payload beat
    localparam int stream_data_bits = adc_pkg::frame_bits;

    // Byte enables
    localparam int stream_keep_bits = stream_data_bits / 8;

    // Payload stream beat, valid and ready travel beside it
    typedef struct packed {
        logic [stream_data_bits-1:0] data;
        logic [stream_keep_bits-1:0] keep;
        logic                        last;  // End of packet
        logic                        user;  // Error or side flag
    } stream_beat_t;

endpackage

/* rtl/adc_input_sync.sv */
`timescale 1ns/1ns

module adc_input_sync (
    input  logic              clk,
    input  logic              rst,
    input  logic              fsync,
    input  logic              dclk,
    input  adc_pkg::lane_bus_t dout,
    output logic              sync_fsync,
    output adc_pkg::lane_bus_t sync_dout,
    output logic              dclk_rise
);
    import adc_pkg::*;

    logic      fsync_meta;
    logic      fsync_sync;
    logic      dclk_meta;
    logic      dclk_sync;
    logic      dclk_dly;  // Previous synchronized dclk level
    lane_bus_t dout_meta;
    lane_bus_t dout_sync;

    // Control pins, cleared so no false edge leaves reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fsync_meta <= 1'b0;
            fsync_sync <= 1'b0;
            dclk_meta  <= 1'b0;
            dclk_sync  <= 1'b0;
            dclk_dly   <= 1'b0;
        end
        else
        begin
            fsync_meta <= fsync;
            fsync_sync <= fsync_meta;
            dclk_meta  <= dclk;
            dclk_sync  <= dclk_meta;
            dclk_dly   <= dclk_sync;
        end
    end

    // Data lanes
    always_ff @(posedge clk)
    begin
        dout_meta <= dout;
        dout_sync <= dout_meta;
    end

    assign sync_fsync = fsync_sync;
    assign sync_dout  = dout_sync;
    assign dclk_rise  = dclk_sync & ~dclk_dly;  // High for one clk per dclk edge

    // dclk at most a quarter of clk, so rises stay four cycles apart
    assert property (@(posedge clk) disable iff (rst)
        dclk_rise |-> !$past(dclk_rise, 2) && !$past(dclk_rise, 3));

endmodule

/* rtl/tdm_deserializer.sv */
`timescale 1ns/1ns

module tdm_deserializer (
    input  logic               clk,
    input  logic               rst,
    input  logic               sync_fsync,
    input  adc_pkg::lane_bus_t sync_dout,
    input  logic               dclk_rise,
    output adc_pkg::adc_frame_t frame,
    output logic               frame_valid
);
    import adc_pkg::*;

    localparam int cnt_bits = $clog2(packet_bits + 1);

    typedef logic [cnt_bits-1:0] cnt_t;

    cnt_t       cnt_q;  // Bits received, zero means idle
    adc_frame_t shift_q;
    adc_frame_t shift_next;
    adc_frame_t frame_q;
    logic       frame_valid_q;
    logic       restart;
    logic       advance;
    logic       complete;

    always_comb
    begin
        for (int i = 0; i < lane_count; i++)
        begin
            shift_next[i] = {shift_q[i][packet_bits-2:0], sync_dout[i]};  // MSB first
        end
    end

    // Sync always wins, even mid packet
    assign restart = dclk_rise && sync_fsync;

    // Extra bits after a full packet fall through here
    assign advance  = dclk_rise && !sync_fsync && (cnt_q != '0)
                      && (cnt_q < cnt_t'(packet_bits));
    assign complete = advance && (cnt_q == cnt_t'(packet_bits - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt_q         <= '0;
            frame_valid_q <= 1'b0;
        end
        else
        begin
            frame_valid_q <= complete;
            if (restart)
            begin
                cnt_q <= cnt_t'(1);
            end
            else if (advance)
            begin
                cnt_q <= cnt_q + cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (restart || advance)
        begin
            shift_q <= shift_next;
        end
        if (complete)
        begin
            frame_q <= shift_next;  // Include the bit arriving now
        end
    end

    assign frame       = frame_q;
    assign frame_valid = frame_valid_q;

    assert property (@(posedge clk) disable iff (rst) cnt_q <= cnt_t'(packet_bits));

endmodule

/* rtl/stream_source_select.sv */
`timescale 1ns/1ns

module stream_source_select (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [3:0]             sw,
    input  adc_pkg::adc_frame_t    frame,
    input  logic                   frame_valid,
    input  stream_pkg::stream_beat_t rx,
    input  logic                   rx_valid,
    output logic                   rx_ready,
    output stream_pkg::stream_beat_t tx,
    output logic                   tx_valid,
    input  logic                   tx_ready
);
    import stream_pkg::*;

    logic         loopback;
    stream_beat_t adc_beat;
    stream_beat_t tx_q;
    logic         tx_valid_q;
    logic         rx_take;

    assign loopback = &sw;  // All four switches up

    always_comb
    begin
        adc_beat.data = frame;
        adc_beat.keep = '1;
        adc_beat.last = 1'b1;  // One frame per packet
        adc_beat.user = 1'b0;
    end

    // ADC mode drains the receive side
    assign rx_ready = loopback ? (!tx_valid_q || tx_ready) : 1'b1;
    assign rx_take  = loopback && rx_valid && rx_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tx_valid_q <= 1'b0;
        end
        else if ((!loopback && frame_valid) || rx_take)
        begin
            tx_valid_q <= 1'b1;
        end
        else if (tx_ready)
        begin
            tx_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rx_take)
        begin
            tx_q <= rx;
        end
        else if (!loopback && frame_valid)
        begin
            tx_q <= adc_beat;  // Newest frame overwrites a pending one
        end
    end

    assign tx       = tx_q;
    assign tx_valid = tx_valid_q;

    // Held beat must survive back-pressure when looping back
    assert property (@(posedge clk) disable iff (rst)
        loopback && tx_valid && !tx_ready |=> $stable(tx) && tx_valid);

endmodule

/* rtl/adc_stream_core.sv */
`timescale 1ns/1ns

module adc_stream_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [3:0]               sw,
    input  logic                     fsync,
    input  logic                     dclk,
    input  adc_pkg::lane_bus_t       dout,
    input  stream_pkg::stream_beat_t rx,
    input  logic                     rx_valid,
    output logic                     rx_ready,
    output stream_pkg::stream_beat_t tx,
    output logic                     tx_valid,
    input  logic                     tx_ready,
    output logic [15:0]              led
);
    import adc_pkg::*;

    logic       sync_fsync;
    lane_bus_t  sync_dout;
    logic       dclk_rise;
    adc_frame_t frame;
    logic       frame_valid;

    adc_input_sync i_sync (
        .clk        (clk),
        .rst        (rst),
        .fsync      (fsync),
        .dclk       (dclk),
        .dout       (dout),
        .sync_fsync (sync_fsync),
        .sync_dout  (sync_dout),
        .dclk_rise  (dclk_rise)
    );

    tdm_deserializer i_deser (
        .clk         (clk),
        .rst         (rst),
        .sync_fsync  (sync_fsync),
        .sync_dout   (sync_dout),
        .dclk_rise   (dclk_rise),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    stream_source_select i_select (
        .clk         (clk),
        .rst         (rst),
        .sw          (sw),
        .frame       (frame),
        .frame_valid (frame_valid),
        .rx          (rx),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .tx          (tx),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready)
    );

    assign led = rx.data[15:0];  // Straight from the receive bus

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    localparam int half_period  = 2;  // 4 ns clock
    localparam int reset_cycles = 8;

    initial
    begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;  // Released on the stimulus edge
    end

endmodule

/* sim/adc_stream_core_tb.sv */
`timescale 1ns/1ns

module adc_stream_core_tb;
    import adc_pkg::*;
    import stream_pkg::*;

    localparam int dclk_half      = 4;  // clk cycles per dclk level
    localparam int frame_gap      = 8;
    localparam int frame_cycles   = 2 * dclk_half * packet_bits + frame_gap;
    localparam int adc_frames     = 26;  // 20, 2, partial plus full, 2 in loopback
    localparam int loop_beats     = 200;
    localparam int beat_cycles    = 8;
    localparam int settle_cycles  = 32;
    localparam int test_cycles    = 16 + adc_frames * frame_cycles
                                    + loop_beats * beat_cycles + 5 * settle_cycles;
    localparam int timeout_cycles = 2 * test_cycles;

    typedef adc_packet_t packet_set_t [lane_count];

    logic         clk;
    logic         rst;
    logic [3:0]   sw;
    logic         fsync;
    logic         dclk;
    lane_bus_t    dout;
    stream_beat_t rx;
    logic         rx_valid;
    logic         rx_ready;
    stream_beat_t tx;
    logic         tx_valid;
    logic         tx_ready;
    logic [15:0]  led;

    stream_beat_t expected_q[$];
    stream_beat_t popped;
    logic [31:0]  rng_state = 32'h4473_690d;
    int           cycle_count = 0;

    tb_clock_gen i_clock (.clk(clk), .rst(rst));

    adc_stream_core i_dut (
        .clk(clk), .rst(rst), .sw(sw), .fsync(fsync), .dclk(dclk), .dout(dout),
        .rx(rx), .rx_valid(rx_valid), .rx_ready(rx_ready),
        .tx(tx), .tx_valid(tx_valid), .tx_ready(tx_ready), .led(led)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Lane 0 lands in the top bits of the payload
    function automatic stream_beat_t expected_adc_beat(input packet_set_t packets);
        stream_beat_t beat;
        beat.data = '0;
        for (int i = 0; i < lane_count; i++)
        begin
            beat.data[frame_bits-1-i*packet_bits -: packet_bits] = packets[i];
        end
        beat.keep = '1;
        beat.last = 1'b1;
        beat.user = 1'b0;
        return beat;
    endfunction

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic check(input string name, input logic [255:0] actual,
                         input logic [255:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic fill_packets(output packet_set_t packets);
        for (int i = 0; i < lane_count; i++)
        begin
            packets[i] = adc_packet_t'(next_random());
        end
    endtask

    task automatic random_beat(output stream_beat_t beat);
        for (int w = 0; w < stream_data_bits / 32; w++)
        begin
            beat.data[w*32 +: 32] = next_random();
        end
        beat.keep = stream_keep_bits'(next_random());
        {beat.last, beat.user} = 2'(next_random());
    endtask

    // ADC model, bits change while dclk falls
    task automatic send_frame(input packet_set_t packets, input int bits);
        for (int b = 0; b < bits; b++)
        begin
            fsync = (b == 0);
            for (int i = 0; i < lane_count; i++)
            begin
                dout[i] = packets[i][packet_bits-1-b];  // MSB first
            end
            repeat (dclk_half) next_cycle();
            dclk = 1'b1;
            repeat (dclk_half) next_cycle();
            dclk = 1'b0;
        end
        fsync = 1'b0;
        repeat (frame_gap) next_cycle();
    endtask

    task automatic hold_until_replaced(input stream_beat_t old_beat,
                                       input stream_beat_t new_beat);
        while (tx !== new_beat)
        begin
            check("tx_valid", 256'(tx_valid), 256'(1));
            check("tx", 256'(tx), 256'(old_beat));
            next_cycle();
        end
    endtask

    task automatic drive_loopback(input int count);
        int           issued;
        int           taken;
        logic         offering;
        logic         accepted;
        logic [31:0]  r;
        stream_beat_t beat;
        issued   = 0;
        taken    = 0;
        offering = 1'b0;
        accepted = 1'b0;
        while (taken < count)
        begin
            next_cycle();
            if (offering && accepted)
            begin
                offering = 1'b0;
                taken++;
            end
            r = next_random();
            if (!offering && issued < count && r[0])
            begin
                random_beat(beat);
                rx = beat;
                expected_q.push_back(beat);
                offering = 1'b1;
                issued++;
            end
            rx_valid = offering;
            tx_ready = r[1];
            @(negedge clk);
            accepted = rx_valid && rx_ready;
        end
        next_cycle();
        tx_ready = 1'b1;
    endtask

    task automatic wait_drained();
        while (expected_q.size() != 0)
        begin
            next_cycle();
        end
        repeat (settle_cycles) next_cycle();  // Room for a stray beat to show
    endtask

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= timeout_cycles)
        begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            stop_run();
        end
    end

    // Checker, sampled mid cycle
    always @(negedge clk)
    begin
        if (!rst)
        begin
            check("led", 256'(led), 256'(rx.data[15:0]));
            if (sw != 4'hf)
            begin
                check("rx_ready", 256'(rx_ready), 256'(1));  // ADC mode drains rx
            end
            if (tx_valid && tx_ready)
            begin
                if (expected_q.size() == 0)
                begin
                    $display("Beat transferred on tx while no beat was expected");
                    stop_run();
                end
                else
                begin
                    popped = expected_q.pop_front();
                    check("tx.data", 256'(tx.data), 256'(popped.data));
                    check("tx.keep", 256'(tx.keep), 256'(popped.keep));
                    check("tx.last", 256'(tx.last), 256'(popped.last));
                    check("tx.user", 256'(tx.user), 256'(popped.user));
                end
            end
        end
    end

    initial
    begin
        packet_set_t  packets;
        packet_set_t  packets_b;
        stream_beat_t beat_a;
        stream_beat_t beat_b;
        sw       = 4'h0;
        fsync    = 1'b0;
        dclk     = 1'b0;
        dout     = '0;
        rx       = '0;
        rx_valid = 1'b0;
        tx_ready = 1'b0;
        wait (!rst);
        repeat (4)
        begin
            next_cycle();
            check("tx_valid", 256'(tx_valid), 256'(0));
        end

        tx_ready = 1'b1;
        for (int f = 0; f < 20; f++)
        begin
            random_beat(rx);  // Idle receive data still drives the LEDs
            fill_packets(packets);
            expected_q.push_back(expected_adc_beat(packets));
            send_frame(packets, packet_bits);
        end
        wait_drained();

        // Back-pressure over two frames
        tx_ready = 1'b0;
        fill_packets(packets);
        beat_a = expected_adc_beat(packets);
        send_frame(packets, packet_bits);
        while (!tx_valid)
        begin
            next_cycle();
        end
        check("tx", 256'(tx), 256'(beat_a));
        fill_packets(packets_b);
        beat_b = expected_adc_beat(packets_b);
        fork
            send_frame(packets_b, packet_bits);
            hold_until_replaced(beat_a, beat_b);
        join
        expected_q.push_back(beat_b);
        tx_ready = 1'b1;
        wait_drained();

        fill_packets(packets);
        send_frame(packets, 10);  // Cut short by the next sync
        fill_packets(packets_b);
        expected_q.push_back(expected_adc_beat(packets_b));
        send_frame(packets_b, packet_bits);
        wait_drained();

        sw = 4'hf;
        fill_packets(packets);
        fill_packets(packets_b);
        fork
            drive_loopback(loop_beats);
            begin
                send_frame(packets, packet_bits);
                send_frame(packets_b, packet_bits);
            end
        join
        wait_drained();

        $display("TEST PASS");
        $finish;
    end

endmodule

/* build.f */
rtl/adc_pkg.sv
rtl/stream_pkg.sv
rtl/adc_input_sync.sv
rtl/tdm_deserializer.sv
rtl/stream_source_select.sv
rtl/adc_stream_core.sv
sim/tb_clock_gen.sv
sim/adc_stream_core_tb.sv

/* Makefile */
TOOL      = verilator
TOP       = adc_stream_core_tb
FILELIST  = build.f
FLAGS     = --timing --assert
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
